/* hdl/cmd_pkg.sv */
/*
  Command side definitions for the configuration loader.
  Holds the ROM word layout, the sequencer constants and the counter
  widths derived from them. Imported by the sequencer, the FIFO, the
  write master and the top level.
*/

`default_nettype none

package cmd_pkg;

  // one ROM word with the register address above the write data
  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] data;
  } cmd_word_t;

  localparam int ROM_DEPTH   = 16;
  localparam int CMD_TOTAL   = 16;
  localparam int CFG_COUNT   = 4;
  localparam int BURST_LEN   = 4;
  localparam int WAIT_GAP    = 3;
  localparam int INIT_CYCLES = 50;
  localparam int FIFO_DEPTH  = 4;

  // derived widths
  localparam int INIT_W  = $clog2(INIT_CYCLES + 1);
  localparam int GAP_W   = $clog2(WAIT_GAP + 1);
  localparam int CNT_W   = $clog2(CMD_TOTAL + 1);
  localparam int ROM_AW  = $clog2(ROM_DEPTH);
  localparam int FIFO_AW = $clog2(FIFO_DEPTH);
  localparam int FIFO_CW = $clog2(FIFO_DEPTH + 1);

endpackage

`default_nettype wire

/* hdl/axil_pkg.sv */
/*
  AXI4-Lite write channel definitions.
  AW, W and B travel as packed structs carrying payload plus valid;
  the matching ready bits are passed as plain single-bit ports.
*/

`default_nettype none

package axil_pkg;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  // write address channel
  typedef struct packed {
    logic [ADDR_W-1:0] awaddr;
    logic              awvalid;
  } axil_aw_t;

  // write data channel with one strobe bit per byte
  typedef struct packed {
    logic [DATA_W-1:0]   wdata;
    logic [DATA_W/8-1:0] wstrb;
    logic                wvalid;
  } axil_w_t;

  // write response channel
  typedef struct packed {
    logic [1:0] bresp;
    logic       bvalid;
  } axil_b_t;

endpackage

`default_nettype wire

/* hdl/cmd_sequencer.sv */
/*
  Command sequencer for the video DMA configuration loader.
  Waits out an init period, then on a frame start edge rewinds the
  ROM and pushes CFG_COUNT setup words; every cmd_start edge pushes
  the next BURST_LEN words. Pushes are spaced and held off while the
  downstream FIFO is full. done rises after CMD_TOTAL pushes.
*/

`timescale 1ns/1ps
`default_nettype none

module cmd_sequencer import cmd_pkg::*; (
  input  wire       clk,
  input  wire       rstn,
  input  wire       frame_start,
  input  wire       cmd_start,
  input  wire       full,
  output logic      push,
  output cmd_word_t push_word,
  output logic      done
);

  typedef enum logic [2:0] {
    s_init,
    s_idle,
    s_cfg_rd,
    s_cfg_wait,
    s_cmd_rd,
    s_cmd_wait
  } state_t;

  state_t            state;
  state_t            state_nxt;
  logic [INIT_W-1:0] init_cnt;
  logic [1:0]        start_d0;
  logic [1:0]        start_d1;
  logic              frame_pos;
  logic              cmd_pos;
  logic [GAP_W-1:0]  gap_cnt;
  logic              gap_ok;
  logic [CNT_W-1:0]  cfg_cnt;
  logic [CNT_W-1:0]  burst_cnt;
  logic [CNT_W-1:0]  total_cnt;
  logic              cfg_end;
  logic              burst_end;
  logic              total_end;
  logic              rd_en;
  logic [ROM_AW-1:0] rom_addr;
  cmd_word_t         rom [ROM_DEPTH];

  initial $readmemh("cmd_rom.hex", rom);

  ////////////////////
  // start inputs
  ////////////////////

  // bit 1 is frame_start, bit 0 is cmd_start
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      start_d0 <= '0;
      start_d1 <= '0;
    end else begin
      start_d0 <= {frame_start, cmd_start};
      start_d1 <= start_d0;
    end
  end

  assign frame_pos = start_d0[1] & ~start_d1[1];
  assign cmd_pos   = start_d0[0] & ~start_d1[0];

  ////////////////////
  // timers and counters
  ////////////////////

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      init_cnt <= '0;
    end else if (state == s_init) begin
      init_cnt <= init_cnt + 1'b1;
    end
  end

  // saturating count of cycles since the last ROM read
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      gap_cnt <= '0;
    end else if (state == s_cfg_rd || state == s_cmd_rd) begin
      gap_cnt <= '0;
    end else if (!gap_ok) begin
      gap_cnt <= gap_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      cfg_cnt   <= '0;
      total_cnt <= '0;
    end else if (frame_pos) begin
      cfg_cnt   <= '0;
      total_cnt <= '0;
    end else if (push) begin
      cfg_cnt   <= cfg_cnt + 1'b1;
      total_cnt <= total_cnt + 1'b1;
    end
  end

  // per burst count restarts on any cmd_start edge seen in idle
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      burst_cnt <= '0;
    end else if (state == s_idle && cmd_pos) begin
      burst_cnt <= '0;
    end else if (push) begin
      burst_cnt <= burst_cnt + 1'b1;
    end
  end

  assign gap_ok    = gap_cnt == GAP_W'(WAIT_GAP - 1);
  assign cfg_end   = cfg_cnt == CNT_W'(CFG_COUNT);
  assign burst_end = burst_cnt == CNT_W'(BURST_LEN);
  assign total_end = total_cnt == CNT_W'(CMD_TOTAL);

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      done <= 1'b0;
    end else if (frame_pos) begin
      done <= 1'b0;
    end else if (total_end) begin
      done <= 1'b1;
    end
  end

  ////////////////////
  // state machine
  ////////////////////

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state <= s_init;
    end else begin
      state <= state_nxt;
    end
  end

  // wait states double as the hold-off point while the FIFO is full
  always_comb begin
    state_nxt = state;
    case (state)
      s_init: begin
        if (init_cnt == INIT_W'(INIT_CYCLES - 1)) state_nxt = s_idle;
      end
      s_idle: begin
        if (frame_pos) state_nxt = s_cfg_wait;
        else if (cmd_pos && !done) state_nxt = s_cmd_wait;
      end
      s_cfg_rd: state_nxt = s_cfg_wait;
      s_cmd_rd: state_nxt = s_cmd_wait;
      s_cfg_wait: begin
        if (cfg_end || total_end) state_nxt = s_idle;
        else if (gap_ok && !full) state_nxt = s_cfg_rd;
      end
      s_cmd_wait: begin
        if (burst_end || total_end) state_nxt = s_idle;
        else if (gap_ok && !full) state_nxt = s_cmd_rd;
      end
      default: state_nxt = s_init;
    endcase
  end

  ////////////////////
  // ROM read and push
  ////////////////////

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      rd_en    <= 1'b0;
      push     <= 1'b0;
      rom_addr <= '0;
    end else begin
      rd_en <= (state == s_cfg_rd || state == s_cmd_rd);
      push  <= rd_en;
      if (frame_pos) rom_addr <= '0;
      else if (rd_en) rom_addr <= rom_addr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en) push_word <= rom[rom_addr];
  end

  // only one word in flight, so the full check at read time must hold
  push_not_full: assert property (@(posedge clk) disable iff (!rstn) push |-> !full);

endmodule

`default_nettype wire

/* hdl/cmd_fifo.sv */
/*
  Small synchronous FIFO between the command sequencer and the
  AXI4-Lite write master. First word falls through into a registered
  head, so a push into an empty FIFO is visible on head one cycle later.
*/

`timescale 1ns/1ps
`default_nettype none

module cmd_fifo import cmd_pkg::*; (
  input  wire       clk,
  input  wire       rstn,
  input  wire       push,
  input  cmd_word_t push_word,
  output logic      full,
  input  wire       pop,
  output cmd_word_t head,
  output logic      empty
);

  cmd_word_t          mem [FIFO_DEPTH];
  logic [FIFO_AW-1:0] wr_ptr;
  logic [FIFO_AW-1:0] rd_ptr;
  logic [FIFO_AW-1:0] rd_ptr_nxt;
  logic [FIFO_CW-1:0] count;

  assign rd_ptr_nxt = pop ? rd_ptr + 1'b1 : rd_ptr;
  assign full       = count == FIFO_CW'(FIFO_DEPTH);
  assign empty      = count == '0;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      rd_ptr <= rd_ptr_nxt;
      if (push) wr_ptr <= wr_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // bypass when the slot being written becomes the new head
  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= push_word;
    if (push && wr_ptr == rd_ptr_nxt) head <= push_word;
    else head <= mem[rd_ptr_nxt];
  end

  no_push_full: assert property (@(posedge clk) disable iff (!rstn) push |-> !full);
  no_pop_empty: assert property (@(posedge clk) disable iff (!rstn) pop |-> !empty);

endmodule

`default_nettype wire

/* hdl/axil_write_master.sv */
/*
  AXI4-Lite write master. Pops one command word at a time from the
  FIFO and issues it as a single write: AW and W are offered together
  and each drops on its own handshake, then the master waits for B.
  One transaction outstanding; strobe is always full width.
*/

`timescale 1ns/1ps
`default_nettype none

module axil_write_master import cmd_pkg::*, axil_pkg::*; (
  input  wire       clk,
  input  wire       rstn,
  input  wire       empty,
  input  cmd_word_t head,
  output logic      pop,
  output axil_aw_t  aw,
  input  wire       awready,
  output axil_w_t   w,
  input  wire       wready,
  input  axil_b_t   b,
  output logic      bready
);

  typedef enum logic [1:0] {
    s_idle,
    s_addr_data,
    s_resp
  } state_t;

  state_t    state;
  cmd_word_t cur;
  logic      aw_done;
  logic      w_done;
  logic      aw_fire;
  logic      w_fire;

  assign pop     = (state == s_idle) && !empty;
  assign aw_fire = aw.awvalid && awready;
  assign w_fire  = w.wvalid && wready;
  assign bready  = state == s_resp;

  always_comb begin
    aw.awaddr  = cur.addr;
    aw.awvalid = (state == s_addr_data) && !aw_done;
    w.wdata    = cur.data;
    w.wstrb    = '1;
    w.wvalid   = (state == s_addr_data) && !w_done;
  end

  always_ff @(posedge clk) begin
    if (pop) cur <= head;
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state   <= s_idle;
      aw_done <= 1'b0;
      w_done  <= 1'b0;
    end else begin
      case (state)
        s_idle: begin
          if (pop) begin
            state   <= s_addr_data;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
          end
        end
        s_addr_data: begin
          if (aw_fire) aw_done <= 1'b1;
          if (w_fire) w_done <= 1'b1;
          // both channels finished in this cycle or earlier
          if ((aw_done || aw_fire) && (w_done || w_fire)) state <= s_resp;
        end
        s_resp: begin
          if (b.bvalid) state <= s_idle;
        end
        default: state <= s_idle;
      endcase
    end
  end

  aw_hold: assert property (@(posedge clk) disable iff (!rstn)
    aw.awvalid && !awready |=> aw.awvalid && $stable(aw.awaddr));
  w_hold: assert property (@(posedge clk) disable iff (!rstn)
    w.wvalid && !wready |=> w.wvalid && $stable(w.wdata));

endmodule

`default_nettype wire

/* hdl/cfg_loader_top.sv */
/*
  Top level of the configuration loader: command sequencer, command
  FIFO and AXI4-Lite write master in a chain. Start inputs come in as
  levels; the AXI write channels go out to the register slave.
*/

`timescale 1ns/1ps
`default_nettype none

module cfg_loader_top import cmd_pkg::*, axil_pkg::*; (
  input  wire      clk,
  input  wire      rstn,
  input  wire      frame_start,
  input  wire      cmd_start,
  output logic     done,
  output axil_aw_t aw,
  input  wire      awready,
  output axil_w_t  w,
  input  wire      wready,
  input  axil_b_t  b,
  output logic     bready
);

  logic      push;
  logic      full;
  logic      pop;
  logic      empty;
  cmd_word_t push_word;
  cmd_word_t head;

  cmd_sequencer u_seq (
    .clk         (clk),
    .rstn        (rstn),
    .frame_start (frame_start),
    .cmd_start   (cmd_start),
    .full        (full),
    .push        (push),
    .push_word   (push_word),
    .done        (done)
  );

  cmd_fifo u_fifo (
    .clk       (clk),
    .rstn      (rstn),
    .push      (push),
    .push_word (push_word),
    .full      (full),
    .pop       (pop),
    .head      (head),
    .empty     (empty)
  );

  axil_write_master u_wr (
    .clk     (clk),
    .rstn    (rstn),
    .empty   (empty),
    .head    (head),
    .pop     (pop),
    .aw      (aw),
    .awready (awready),
    .w       (w),
    .wready  (wready),
    .b       (b),
    .bready  (bready)
  );

endmodule

`default_nettype wire

/* verification/tb_cfg_loader.sv */
/*
  Testbench for the configuration loader top level.
  Acts as an AXI4-Lite slave with random ready and response delays,
  issues frame and command start edges, and checks every AW and W
  handshake against a model that walks the command ROM image.
  Run from the project root so that cmd_rom.hex is found.
*/

`timescale 1ns/1ps
`default_nettype none

module tb_cfg_loader import cmd_pkg::*, axil_pkg::*;;

  localparam int QUIET_CYCLES  = 100;
  localparam int IGNORE_CYCLES = 40;
  localparam int SETTLE_CYCLES = 40;
  localparam int WRITE_TIMEOUT = 400;
  localparam int RANDOM_EVENTS = 24;

  logic     clk = 1'b0;
  logic     rstn;
  logic     frame_start;
  logic     cmd_start;
  logic     done;
  axil_aw_t aw;
  logic     awready = 1'b0;
  axil_w_t  w;
  logic     wready = 1'b0;
  axil_b_t  b = '0;
  logic     bready;

  // reference model state
  cmd_word_t         rom_model [ROM_DEPTH];
  logic [ROM_AW-1:0] m_ptr = '0;
  int                m_total = 0;
  logic [31:0]       exp_addr [$];
  logic [31:0]       exp_data [$];
  int                b_count = 0;
  int                b_target = 0;
  int                b_wait = 0;
  logic              quiet = 1'b1;
  logic              stall = 1'b0;

  cfg_loader_top dut (
    .clk         (clk),
    .rstn        (rstn),
    .frame_start (frame_start),
    .cmd_start   (cmd_start),
    .done        (done),
    .aw          (aw),
    .awready     (awready),
    .w           (w),
    .wready      (wready),
    .b           (b),
    .bready      (bready)
  );

  always #20 clk = ~clk;

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("SOME TESTS FAILED");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      stop_run($sformatf("Fail %s: got %h expected %h", name, got, exp));
    end
  endtask

  ////////////////////
  // slave side
  ////////////////////

  // readies and response change on the falling edge only
  always @(negedge clk) begin
    if (!rstn) begin
      awready <= 1'b0;
      wready  <= 1'b0;
      b       <= '0;
      b_wait  <= 0;
    end else begin
      awready <= (($urandom % 3) != 0) && !stall;
      wready  <= (($urandom % 3) != 0) && !stall;
      if (b.bvalid) begin
        // bready low again means the response went through
        if (!bready) b.bvalid <= 1'b0;
      end else if (bready) begin
        if (b_wait == 0) begin
          b.bvalid <= 1'b1;
          b_wait   <= $urandom % 4;
        end else begin
          b_wait <= b_wait - 1;
        end
      end
    end
  end

  ////////////////////
  // monitor
  ////////////////////

  always @(posedge clk) begin
    if (rstn) begin
      if (quiet && (aw.awvalid || w.wvalid || done)) begin
        stop_run("write valid or done raised before any start edge");
      end
      if (aw.awvalid && awready) begin
        if (exp_addr.size() == 0) stop_run("AW handshake with no write expected");
        else check_value("awaddr", aw.awaddr, exp_addr.pop_front());
      end
      if (w.wvalid && wready) begin
        check_value("wstrb", 32'(w.wstrb), 32'hf);
        if (exp_data.size() == 0) stop_run("W handshake with no write expected");
        else check_value("wdata", w.wdata, exp_data.pop_front());
      end
      if (b.bvalid && bready) b_count++;
    end
  end

  ////////////////////
  // stimulus
  ////////////////////

  // a frame rewinds the pointer and a burst continues from it up to the per frame cap
  task automatic load_expected(input bit is_frame, output int n);
    if (is_frame) begin
      m_ptr   = '0;
      m_total = 0;
      n       = CFG_COUNT;
    end else if (m_total >= CMD_TOTAL) begin
      n = 0;
    end else begin
      n = BURST_LEN;
    end
    if (n > CMD_TOTAL - m_total) n = CMD_TOTAL - m_total;
    for (int i = 0; i < n; i++) begin
      exp_addr.push_back(rom_model[m_ptr].addr);
      exp_data.push_back(rom_model[m_ptr].data);
      m_ptr   = m_ptr + 1'b1;
      m_total = m_total + 1;
    end
    b_target += n;
  endtask

  task automatic pulse_start(input bit is_frame);
    int hold;
    hold = 1 + ($urandom % 4);
    @(negedge clk);
    if (is_frame) frame_start = 1'b1;
    else cmd_start = 1'b1;
    repeat (hold) @(negedge clk);
    frame_start = 1'b0;
    cmd_start   = 1'b0;
  endtask

  task automatic wait_writes();
    int cycles;
    cycles = 0;
    while (b_count < b_target && cycles < WRITE_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (b_count < b_target) stop_run("timeout waiting for AXI write responses");
  endtask

  task automatic run_event(input bit is_frame);
    int n;
    load_expected(is_frame, n);
    pulse_start(is_frame);
    // ignored starts get a window in which no write may show up
    if (n > 0) wait_writes();
    else repeat (IGNORE_CYCLES) @(negedge clk);
    check_value("done", 32'(done), 32'(m_total >= CMD_TOTAL));
    repeat (2 + $urandom % 4) @(negedge clk);
  endtask

  // two bursts queued behind a stalled slave until the FIFO runs full
  task automatic fill_fifo();
    int n;
    stall <= 1'b1;
    load_expected(1'b0, n);
    pulse_start(1'b0);
    repeat (SETTLE_CYCLES) @(negedge clk);
    load_expected(1'b0, n);
    pulse_start(1'b0);
    repeat (SETTLE_CYCLES) @(negedge clk);
    stall <= 1'b0;
    wait_writes();
    check_value("done", 32'(done), 32'(m_total >= CMD_TOTAL));
  endtask

  initial begin
    void'($urandom(68806));
    rstn        = 1'b0;
    frame_start = 1'b0;
    cmd_start   = 1'b0;
    $readmemh("cmd_rom.hex", rom_model);
    repeat (8) @(negedge clk);
    rstn <= 1'b1;
    // init period plus idle time with no starts
    repeat (QUIET_CYCLES) @(negedge clk);
    quiet = 1'b0;

    run_event(1'b1);
    fill_fifo();
    run_event(1'b0);
    // done is high now so further bursts are ignored
    repeat (2) run_event(1'b0);
    run_event(1'b1);
    for (int i = 0; i < RANDOM_EVENTS; i++) begin
      run_event(($urandom % 4) == 0);
    end

    if (exp_addr.size() != 0 || exp_data.size() != 0 || b_count != b_target) begin
      stop_run("expected writes left over at the end of the run");
    end else begin
      $display("ALL TESTS PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* cmd_rom.hex */
// one word per line: register address in bits 63:32, write data in bits 31:0
// words 0-3 are frame setup, the rest are command bursts
4000000000000000
4000000400000780
4000000800000438
4000000c00001e00
4000001080000000
40000014807e9000
4000001880fd2000
4000001c00000003
4000002000000010
400000240000000f
4000002800000001
4000002c000000ff
4000003000000002
4000003400000000
400000380000ffff
4000003c00000001

/* cfg_loader_top.f */
hdl/cmd_pkg.sv
hdl/axil_pkg.sv
hdl/cmd_sequencer.sv
hdl/cmd_fifo.sv
hdl/axil_write_master.sv
hdl/cfg_loader_top.sv
verification/tb_cfg_loader.sv

/* Makefile */
SRCS := $(shell cat cfg_loader_top.f)

.PHONY: run clean

run: obj_dir/Vtb_cfg_loader
	./obj_dir/Vtb_cfg_loader

obj_dir/Vtb_cfg_loader: cfg_loader_top.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_cfg_loader -f cfg_loader_top.f

clean:
	rm -rf obj_dir
